// ==== hdl/rv32i_types.sv ====
package rv32i_types;

    // basic data and index widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] order_t;

    // raw instruction field widths
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // base opcodes, only lui, imm and reg are executed
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_fence = 7'b0001111,
        op_sys   = 7'b1110011
    } rv32i_opcode_t;

    // funct3 of the integer arithmetic group
    typedef enum funct3_t {
        arith_f3_add  = 3'b000,
        arith_f3_sll  = 3'b001,
        arith_f3_slt  = 3'b010,
        arith_f3_sltu = 3'b011,
        arith_f3_xor  = 3'b100,
        arith_f3_sr   = 3'b101,
        arith_f3_or   = 3'b110,
        arith_f3_and  = 3'b111
    } arith_f3_t;

    // funct7 forms, variant picks sub and sra
    localparam funct7_t funct7_base    = 7'b0000000;
    localparam funct7_t funct7_variant = 7'b0100000;

    // low three bits follow funct3, bit 3 marks the variant ops
    typedef enum logic [3:0] {
        alu_op_add  = 4'b0000,
        alu_op_sll  = 4'b0001,
        alu_op_slt  = 4'b0010,
        alu_op_sltu = 4'b0011,
        alu_op_xor  = 4'b0100,
        alu_op_srl  = 4'b0101,
        alu_op_or   = 4'b0110,
        alu_op_and  = 4'b0111,
        alu_op_sub  = 4'b1000,
        alu_op_sra  = 4'b1101,
        alu_op_none = 4'b1111
    } alu_op_t;

    // operand source selects
    typedef enum logic {m1_rs1 = 1'b0, m1_zero = 1'b1} m1_sel_t;
    typedef enum logic {m2_rs2 = 1'b0, m2_imm = 1'b1} m2_sel_t;

endpackage

// ==== hdl/fetch.sv ====
`timescale 1ns/10ps

module fetch #(
    parameter rv32i_types::word_t reset_pc = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst_valid,
    input  rv32i_types::word_t  inst,
    output logic                f_valid,
    output rv32i_types::word_t  f_inst,
    output rv32i_types::word_t  f_pc,
    output rv32i_types::order_t f_order
);

    // pc and sequence number for the next accepted word
    rv32i_types::word_t  pc_q;
    rv32i_types::order_t order_q;

    // counters only move on a strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q    <= reset_pc;
            order_q <= '0;
            f_valid <= 1'b0;
        end else begin
            // one cycle pulse per accepted word
            f_valid <= inst_valid;
            if (inst_valid) begin
                // no branches, so pc only steps forward
                pc_q    <= pc_q + 32'd4;
                order_q <= order_q + 32'd1;
            end
        end
    end

    // payload capture with current pc and order
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            f_inst  <= inst;
            f_pc    <= pc_q;
            f_order <= order_q;
        end
    end

endmodule

// ==== hdl/decode.sv ====
`timescale 1ns/10ps

module decode (
    input  logic                     f_valid,
    input  rv32i_types::word_t       f_inst,
    input  rv32i_types::word_t       f_pc,
    input  rv32i_types::order_t      f_order,
    output logic                     d_valid,
    output rv32i_types::word_t       d_inst,
    output rv32i_types::word_t       d_pc,
    output rv32i_types::order_t      d_order,
    output rv32i_types::reg_addr_t   rs1_addr,
    output rv32i_types::reg_addr_t   rs2_addr,
    output rv32i_types::reg_addr_t   rd_addr,
    output rv32i_types::word_t       imm,
    output logic                     regf_we,
    output logic                     use_rs1,
    output logic                     use_rs2,
    output rv32i_types::m1_sel_t     m1_sel,
    output rv32i_types::m2_sel_t     m2_sel,
    output rv32i_types::alu_op_t     aluop,
    output logic                     illegal
);

    rv32i_types::rv32i_opcode_t opcode;
    rv32i_types::arith_f3_t     funct3;
    rv32i_types::funct7_t       funct7;
    rv32i_types::word_t         i_imm;
    rv32i_types::word_t         u_imm;

    // raw fields
    assign opcode   = rv32i_types::rv32i_opcode_t'(f_inst[6:0]);
    assign funct3   = rv32i_types::arith_f3_t'(f_inst[14:12]);
    assign funct7   = f_inst[31:25];
    assign rs1_addr = f_inst[19:15];
    assign rs2_addr = f_inst[24:20];
    assign rd_addr  = f_inst[11:7];

    // only the I and U forms are needed here
    assign i_imm = {{21{f_inst[31]}}, f_inst[30:20]};
    assign u_imm = {f_inst[31:12], 12'h000};

    // tag fields pass straight to execute
    assign d_valid = f_valid;
    assign d_inst  = f_inst;
    assign d_pc    = f_pc;
    assign d_order = f_order;

    always_comb begin
        // safe defaults, nothing written and flagged illegal
        imm     = '0;
        regf_we = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        m1_sel  = rv32i_types::m1_zero;
        m2_sel  = rv32i_types::m2_imm;
        aluop   = rv32i_types::alu_op_none;
        illegal = 1'b1;

        case (opcode)
            rv32i_types::op_lui: begin
                // zero plus upper immediate
                imm     = u_imm;
                regf_we = 1'b1;
                aluop   = rv32i_types::alu_op_add;
                illegal = 1'b0;
            end
            rv32i_types::op_imm: begin
                imm     = i_imm;
                regf_we = 1'b1;
                use_rs1 = 1'b1;
                m1_sel  = rv32i_types::m1_rs1;
                illegal = 1'b0;
                if (funct3 == rv32i_types::arith_f3_sr) begin
                    // shift type comes from imm[10]
                    aluop = (funct7 == rv32i_types::funct7_variant) ?
                            rv32i_types::alu_op_sra : rv32i_types::alu_op_srl;
                end else begin
                    aluop = rv32i_types::alu_op_t'({1'b0, funct3});
                end
            end
            rv32i_types::op_reg: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                m1_sel  = rv32i_types::m1_rs1;
                m2_sel  = rv32i_types::m2_rs2;
                if (funct7 == rv32i_types::funct7_base) begin
                    aluop = rv32i_types::alu_op_t'({1'b0, funct3});
                end else if (funct7 == rv32i_types::funct7_variant &&
                             funct3 == rv32i_types::arith_f3_add) begin
                    aluop = rv32i_types::alu_op_sub;
                end else if (funct7 == rv32i_types::funct7_variant &&
                             funct3 == rv32i_types::arith_f3_sr) begin
                    aluop = rv32i_types::alu_op_sra;
                end
                // unknown funct7 keeps op none and no write
                illegal = (aluop == rv32i_types::alu_op_none);
                regf_we = !illegal;
            end
            rv32i_types::op_auipc, rv32i_types::op_jal, rv32i_types::op_jalr,
            rv32i_types::op_br, rv32i_types::op_load, rv32i_types::op_store,
            rv32i_types::op_fence, rv32i_types::op_sys: begin
                // valid base opcode but not built in this core
                illegal = 1'b1;
            end
            default: begin
                // not an RV32I opcode at all
                illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  rv32i_types::word_t   a,
    input  rv32i_types::word_t   b,
    input  rv32i_types::alu_op_t aluop,
    output rv32i_types::word_t   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // shifts only look at the low five bits
    assign shamt = b[4:0];

    // compare results shared by slt and sltu
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (aluop)
            rv32i_types::alu_op_add:  result = a + b;
            rv32i_types::alu_op_sub:  result = a - b;
            rv32i_types::alu_op_sll:  result = a << shamt;
            rv32i_types::alu_op_slt:  result = {31'b0, lt_signed};
            rv32i_types::alu_op_sltu: result = {31'b0, lt_unsigned};
            rv32i_types::alu_op_xor:  result = a ^ b;
            rv32i_types::alu_op_srl:  result = a >> shamt;
            // arithmetic shift keeps the sign bit
            rv32i_types::alu_op_sra:  result = $unsigned($signed(a) >>> shamt);
            rv32i_types::alu_op_or:   result = a | b;
            rv32i_types::alu_op_and:  result = a & b;
            // none and any unused code give zero
            default:                  result = '0;
        endcase
    end

endmodule

// ==== hdl/regfile.sv ====
`timescale 1ns/10ps

module regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv32i_types::reg_addr_t rs1_addr,
    input  rv32i_types::reg_addr_t rs2_addr,
    output rv32i_types::word_t     rs1_data,
    output rv32i_types::word_t     rs2_data,
    input  logic                   we,
    input  rv32i_types::reg_addr_t rd_addr,
    input  rv32i_types::word_t     rd_data
);

    rv32i_types::word_t regs [32];

    // all registers start at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != '0) begin
            // x0 never takes a write
            regs[rd_addr] <= rd_data;
        end
    end

    // asynchronous read ports
    // x0 forced to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hdl/execute.sv ====
`timescale 1ns/10ps

module execute (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   d_valid,
    input  rv32i_types::word_t     d_inst,
    input  rv32i_types::word_t     d_pc,
    input  rv32i_types::order_t    d_order,
    input  rv32i_types::reg_addr_t rs1_addr,
    input  rv32i_types::reg_addr_t rs2_addr,
    input  rv32i_types::reg_addr_t rd_addr,
    input  rv32i_types::word_t     imm,
    input  logic                   regf_we,
    input  logic                   use_rs1,
    input  logic                   use_rs2,
    input  rv32i_types::m1_sel_t   m1_sel,
    input  rv32i_types::m2_sel_t   m2_sel,
    input  rv32i_types::alu_op_t   aluop,
    input  logic                   illegal,
    output logic                   commit_valid,
    output rv32i_types::order_t    commit_order,
    output rv32i_types::word_t     commit_pc,
    output rv32i_types::word_t     commit_inst,
    output rv32i_types::reg_addr_t commit_rd,
    output logic                   commit_we,
    output logic                   commit_value_unused_guard,
    output rv32i_types::word_t     commit_value,
    output logic                   commit_illegal
);

    // read addresses, x0 when the operand is not needed
    rv32i_types::reg_addr_t rd1_addr;
    rv32i_types::reg_addr_t rd2_addr;
    rv32i_types::word_t     rs1_data;
    rv32i_types::word_t     rs2_data;
    rv32i_types::word_t     op_a;
    rv32i_types::word_t     op_b;
    rv32i_types::word_t     alu_result;
    logic                   rf_we;

    assign rd1_addr = use_rs1 ? rs1_addr : '0;
    assign rd2_addr = use_rs2 ? rs2_addr : '0;

    // write lands at the same edge as the commit
    regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rd1_addr),
        .rs2_addr (rd2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .rd_addr  (rd_addr),
        .rd_data  (alu_result)
    );

    // operand source muxes
    assign op_a = (m1_sel == rv32i_types::m1_rs1) ? rs1_data : '0;
    assign op_b = (m2_sel == rv32i_types::m2_rs2) ? rs2_data : imm;

    alu u_alu (
        .a      (op_a),
        .b      (op_b),
        .aluop  (aluop),
        .result (alu_result)
    );

    // only a valid write to x1..x31 happens
    assign rf_we = d_valid && regf_we && (rd_addr != '0);

    // commit register, one pulse per retired instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_valid   <= 1'b0;
            commit_order   <= '0;
            commit_pc      <= '0;
            commit_inst    <= '0;
            commit_rd      <= '0;
            commit_we      <= 1'b0;
            commit_value   <= '0;
            commit_illegal <= 1'b0;
        end else begin
            commit_valid <= d_valid;
            if (d_valid) begin
                commit_order   <= d_order;
                commit_pc      <= d_pc;
                commit_inst    <= d_inst;
                commit_rd      <= rd_addr;
                // reports the write that really happened
                commit_we      <= rf_we;
                commit_value   <= alu_result;
                commit_illegal <= illegal;
            end
        end
    end

    // retired value that never reached the register file
    assign commit_value_unused_guard = commit_valid && !commit_we;

endmodule

// ==== hdl/rv32i_frontend.sv ====
`timescale 1ns/10ps

module rv32i_frontend #(
    parameter rv32i_types::word_t reset_pc = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_valid,
    input  rv32i_types::word_t     inst,
    output logic                   commit_valid,
    output rv32i_types::order_t    commit_order,
    output rv32i_types::word_t     commit_pc,
    output rv32i_types::word_t     commit_inst,
    output rv32i_types::reg_addr_t commit_rd,
    output logic                   commit_we,
    output rv32i_types::word_t     commit_value,
    output logic                   commit_illegal
);

    // fetch register outputs
    logic                   f_valid;
    rv32i_types::word_t     f_inst;
    rv32i_types::word_t     f_pc;
    rv32i_types::order_t    f_order;

    // decoded control, combinational
    logic                   d_valid;
    rv32i_types::word_t     d_inst;
    rv32i_types::word_t     d_pc;
    rv32i_types::order_t    d_order;
    rv32i_types::reg_addr_t rs1_addr;
    rv32i_types::reg_addr_t rs2_addr;
    rv32i_types::reg_addr_t rd_addr;
    rv32i_types::word_t     imm;
    logic                   regf_we;
    logic                   use_rs1;
    logic                   use_rs2;
    rv32i_types::m1_sel_t   m1_sel;
    rv32i_types::m2_sel_t   m2_sel;
    rv32i_types::alu_op_t   aluop;
    logic                   illegal;

    // spare execute output, not brought out
    logic                   commit_value_unused_guard;

    fetch #(.reset_pc(reset_pc)) u_fetch (.*);

    decode u_decode (.*);

    // register file and ALU live inside execute
    execute u_execute (.*);

endmodule

// ==== tb/tb_checker.sv ====
`timescale 1ns/10ps

module tb_checker #(
    parameter rv32i_types::word_t reset_pc = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_valid,
    input  rv32i_types::word_t     inst,
    input  rv32i_types::reg_addr_t exp_rd,
    input  logic                   exp_we,
    input  rv32i_types::word_t     exp_value,
    input  logic                   exp_illegal,
    input  logic                   commit_valid,
    input  rv32i_types::order_t    commit_order,
    input  rv32i_types::word_t     commit_pc,
    input  rv32i_types::word_t     commit_inst,
    input  rv32i_types::reg_addr_t commit_rd,
    input  logic                   commit_we,
    input  rv32i_types::word_t     commit_value,
    input  logic                   commit_illegal,
    output int                     errors,
    output int                     commits,
    output int                     pending,
    output rv32i_types::order_t    next_order
);

    // one outstanding instruction, tagged at its strobe
    typedef struct packed {
        rv32i_types::order_t    order;
        rv32i_types::word_t     pc;
        rv32i_types::word_t     inst;
        rv32i_types::reg_addr_t rd;
        logic                   we;
        rv32i_types::word_t     value;
        logic                   illegal;
        logic [31:0]            cycle;
    } expect_t;

    expect_t             expected [$];
    rv32i_types::word_t  pc_next;
    rv32i_types::order_t order_next;
    logic [31:0]         cycle;

    task automatic compare_field(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
        if (want !== got) begin
            $display("** Error: %s expected %h got %h", name, want, got);
            errors++;
        end
    endtask

    task automatic check_commit();
        expect_t e;
        if (expected.size() == 0) begin
            $display("commit of order %0d arrived with nothing outstanding", commit_order);
            errors++;
        end else begin
            e = expected.pop_front();
            commits++;
            compare_field("commit_order", e.order, commit_order);
            compare_field("commit_pc", e.pc, commit_pc);
            compare_field("commit_inst", e.inst, commit_inst);
            compare_field("commit_rd", {27'b0, e.rd}, {27'b0, commit_rd});
            compare_field("commit_we", {31'b0, e.we}, {31'b0, commit_we});
            compare_field("commit_illegal", {31'b0, e.illegal}, {31'b0, commit_illegal});
            // value of an illegal instruction is not architectural
            if (!e.illegal) compare_field("commit_value", e.value, commit_value);
            // fixed two cycle latency from strobe to commit
            if (cycle - e.cycle != 32'd2) begin
                $display("commit of order %0d took %0d cycles instead of 2",
                         e.order, cycle - e.cycle);
                errors++;
            end
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            expected.delete();
            pc_next    = reset_pc;
            order_next = '0;
            cycle      = '0;
            errors     = 0;
            commits    = 0;
        end else begin
            cycle = cycle + 32'd1;
            // a commit never belongs to a strobe of the same edge
            if (commit_valid) check_commit();
            if (inst_valid) begin
                expected.push_back(expect_t'({order_next, pc_next, inst, exp_rd, exp_we,
                                              exp_value, exp_illegal, cycle}));
                pc_next    = pc_next + 32'd4;
                order_next = order_next + 32'd1;
            end
        end
        pending    = expected.size();
        next_order = (expected.size() != 0) ? expected[0].order : order_next;
    end

endmodule

// ==== tb/tb_top.sv ====
`timescale 1ns/10ps

module tb_top;

    localparam rv32i_types::word_t start_pc = 32'h0000_1000;
    localparam logic [6:0]         alt      = 7'b0100000;

    logic                   clk;
    logic                   rst_n;
    logic                   inst_valid;
    rv32i_types::word_t     inst;
    logic                   commit_valid;
    rv32i_types::order_t    commit_order;
    rv32i_types::word_t     commit_pc;
    rv32i_types::word_t     commit_inst;
    rv32i_types::reg_addr_t commit_rd;
    logic                   commit_we;
    rv32i_types::word_t     commit_value;
    logic                   commit_illegal;

    // in-order model of the architectural registers
    rv32i_types::word_t     model_regs [32];
    rv32i_types::reg_addr_t exp_rd;
    logic                   exp_we;
    rv32i_types::word_t     exp_value;
    logic                   exp_illegal;
    int                     errors;
    int                     commits;
    int                     pending;
    rv32i_types::order_t    next_order;
    int                     errors_seen;
    int                     seed;

    rv32i_frontend #(.reset_pc(start_pc)) i_dut (.*);

    tb_checker #(.reset_pc(start_pc)) u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // expected rd, write, value and illegal flag for one word
    function automatic void predict(input rv32i_types::word_t w,
                                    input rv32i_types::word_t regs [32],
                                    output rv32i_types::reg_addr_t rd, output logic we,
                                    output rv32i_types::word_t value, output logic ill);
        rv32i_types::word_t a;
        rv32i_types::word_t b;
        logic               sub_sra;
        a       = regs[w[19:15]];
        b       = (w[6:0] == 7'b0010011) ? {{20{w[31]}}, w[31:20]} : regs[w[24:20]];
        sub_sra = (w[31:25] == alt);
        rd      = w[11:7];
        value   = '0;
        ill     = 1'b0;
        if (w[6:0] == 7'b0110111) begin
            value = {w[31:12], 12'h000};
        end else if (w[6:0] == 7'b0010011 || w[6:0] == 7'b0110011) begin
            if (w[6:0] == 7'b0110011) begin
                // reg form only knows base, sub and sra
                ill = !(w[31:25] == 7'b0 || (sub_sra && (w[14:12] == 3'b000 ||
                                                          w[14:12] == 3'b101)));
            end else begin
                sub_sra = sub_sra && (w[14:12] == 3'b101);
            end
            case (w[14:12])
                3'b000:  value = sub_sra ? a - b : a + b;
                3'b001:  value = a << b[4:0];
                // flipped sign bits turn signed order into unsigned
                3'b010:  value = {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
                3'b011:  value = {31'b0, a < b};
                3'b100:  value = a ^ b;
                3'b101:  value = (a >> b[4:0]) |
                                 ((sub_sra && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
                3'b110:  value = a | b;
                default: value = a & b;
            endcase
        end else begin
            ill = 1'b1;
        end
        we = !ill && rd != 5'd0;
    endfunction

    always_comb predict(inst, model_regs, exp_rd, exp_we, exp_value, exp_illegal);

    // model retires at the strobe, x0 never written
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) model_regs[i] <= '0;
        end else if (inst_valid && exp_we) begin
            model_regs[exp_rd] <= exp_value;
        end
    end

    function automatic rv32i_types::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                                  input logic [4:0] rs1, input logic [2:0] f3,
                                                  input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv32i_types::word_t i_type(input logic [11:0] imm12,
                                                  input logic [4:0] rs1, input logic [2:0] f3,
                                                  input logic [4:0] rd);
        return {imm12, rs1, f3, rd, 7'b0010011};
    endfunction

    task automatic issue(input rv32i_types::word_t word);
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = word;
    endtask

    task automatic gap(input int cycles);
        @(negedge clk);
        inst_valid = 1'b0;
        repeat (cycles - 1) @(negedge clk);
    endtask

    // wait for every outstanding commit, then report the test
    task automatic drain(input string name);
        int waited;
        waited = 0;
        gap(1);
        while (pending != 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("test %s: commit of order %0d never arrived", name, next_order);
            $display(">>> FAIL");
            $finish;
        end else begin
            $display("test %s done, %0d errors", name, errors - errors_seen);
            errors_seen = errors;
        end
    endtask

    initial begin
        rv32i_types::word_t w;
        int                 kind;
        seed        = 85266;
        errors_seen = 0;
        rst_n       = 1'b0;
        inst_valid  = 1'b0;
        inst        = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // quiet after reset, then pc and order from the start
        gap(8);
        issue({20'h12345, 5'd1, 7'b0110111});
        issue(i_type(12'hfff, 5'd1, 3'b000, 5'd2));
        issue(i_type(12'h004, 5'd2, 3'b000, 5'd3));
        drain("reset_sequence");

        issue({20'h80000, 5'd4, 7'b0110111});
        issue(i_type({alt, 5'd4}, 5'd4, 3'b101, 5'd5));
        issue(i_type(12'h004, 5'd4, 3'b101, 5'd6));
        gap(2);
        // -2048, then compares against it
        issue(i_type(12'h800, 5'd0, 3'b000, 5'd7));
        issue(i_type(12'h005, 5'd7, 3'b010, 5'd8));
        issue(i_type(12'h005, 5'd7, 3'b011, 5'd9));
        issue(i_type(12'hf0f, 5'd1, 3'b100, 5'd10));
        issue(i_type(12'h0f0, 5'd1, 3'b110, 5'd11));
        issue(i_type(12'hff0, 5'd1, 3'b111, 5'd12));
        issue(i_type(12'h01f, 5'd2, 3'b001, 5'd13));
        drain("lui_op_imm");

        // each op reads the result of the one before
        issue(r_type(7'b0, 5'd2, 5'd1, 3'b000, 5'd14));
        issue(r_type(alt, 5'd4, 5'd14, 3'b000, 5'd14));
        issue(r_type(alt, 5'd3, 5'd14, 3'b101, 5'd15));
        issue(r_type(7'b0, 5'd3, 5'd15, 3'b101, 5'd16));
        issue(r_type(7'b0, 5'd15, 5'd16, 3'b010, 5'd17));
        issue(r_type(7'b0, 5'd15, 5'd16, 3'b011, 5'd18));
        issue(r_type(7'b0, 5'd17, 5'd18, 3'b100, 5'd19));
        issue(r_type(7'b0, 5'd14, 5'd19, 3'b110, 5'd19));
        issue(r_type(7'b0, 5'd19, 5'd19, 3'b001, 5'd20));
        issue(r_type(7'b0, 5'd20, 5'd4, 3'b111, 5'd20));
        drain("op_chain");

        issue(i_type(12'h123, 5'd1, 3'b000, 5'd0));
        issue(r_type(7'b0, 5'd0, 5'd0, 3'b000, 5'd21));
        drain("x0_write");

        // store, mul encoding and a non rv32i opcode
        issue({7'h00, 5'd1, 5'd2, 3'b010, 5'd14, 7'b0100011});
        issue(r_type(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd15));
        issue({25'h1ff_ffff, 7'b1111111});
        issue(r_type(7'b0, 5'd15, 5'd14, 3'b000, 5'd22));
        drain("illegal");

        for (int n = 0; n < 300; n++) begin
            w    = $random(seed);
            kind = $random(seed);
            // x0..x7 only, so dependencies are frequent
            w[24:23] = 2'b00;
            w[19:18] = 2'b00;
            w[11:10] = 2'b00;
            if (kind[1:0] == 2'd0) begin
                w[6:0] = 7'b0110111;
            end else if (kind[1:0] == 2'd1) begin
                w[6:0] = 7'b0010011;
                if (w[14:12] == 3'b101) w[31:25] = w[31] ? alt : 7'b0;
            end else begin
                w[6:0]   = 7'b0110011;
                w[31:25] = w[31] ? alt : 7'b0;
            end
            issue(w);
            if (kind[5:4] != 2'd0) gap(int'(kind[5:4]));
        end
        drain("random_stream");

        $display("tests done: %0d commits checked, %0d errors", commits, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hdl/rv32i_types.sv
hdl/fetch.sv
hdl/decode.sv
hdl/alu.sv
hdl/regfile.sv
hdl/execute.sv
hdl/rv32i_frontend.sv
tb/tb_checker.sv
tb/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the RV32I front end testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f tb.f --top-module tb_top -Mdir obj_dir -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    || echo "build or simulation did not complete" >> sim.log
grep -qx '>>> PASS' sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
